// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_instr_buffer
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "FAIL"; exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/ibuf_params.svh ====
`ifndef IBUF_PARAMS_SVH
`define IBUF_PARAMS_SVH

//////////////////////////////////////////////////
// Instruction buffer sizing
//////////////////////////////////////////////////

// Number of stored entries, must be a power of two
`define IBUF_DEPTH    16

// Datapath width of instr, pc, imm and pred_pc
`define IBUF_XLEN     32

// Fetch slots and decode lanes per cycle
`define IBUF_FETCH_W  3
`define IBUF_ISSUE_W  3

// RV32I canonical NOP, addi x0, x0, 0
`define IBUF_NOP      32'h0000_0013

`endif

// ==== src/ibuf_entry_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ibuf_params.svh"

module ibuf_entry_ram (
    input  wire                      clk,
    input  ibuf_pkg::fetch_mask_t    write_en_i,
    input  ibuf_pkg::ibuf_ptr_t      tail_ptr_i,
    input  ibuf_pkg::ibuf_entry_t    wr_entries_i [`IBUF_FETCH_W],
    input  ibuf_pkg::ibuf_ptr_t      head_ptr_i,
    input  ibuf_pkg::lane_mask_t     lane_valid_i,
    input  ibuf_pkg::lane_avail_t    lane_offset_i [`IBUF_ISSUE_W],
    output ibuf_pkg::ibuf_entry_t    rd_entries_o [`IBUF_ISSUE_W]
);

    import ibuf_pkg::*;

    // Shown on lanes that carry nothing
    localparam ibuf_entry_t NOP_ENTRY = '{
        instr:      `IBUF_NOP,
        pc:         '0,
        imm:        '0,
        pred_pc:    '0,
        pred_taken: 1'b0
    };

    ibuf_entry_t mem [`IBUF_DEPTH];

    ibuf_ptr_t wr_addr [`IBUF_FETCH_W];
    ibuf_ptr_t rd_addr [`IBUF_ISSUE_W];
    ibuf_ptr_t wr_ofs;

    //////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////

    // Each enabled slot lands after the enabled slots below it,
    // so a mask like 101 fills two consecutive entries
    always_comb begin
        wr_ofs = '0;
        for (int i = 0; i < `IBUF_FETCH_W; i++) begin
            wr_addr[i] = tail_ptr_i + wr_ofs;
            if (write_en_i[i]) begin
                wr_ofs = wr_ofs + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `IBUF_FETCH_W; i++) begin
            if (write_en_i[i]) begin
                mem[wr_addr[i]] <= wr_entries_i[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////

    // Offsets come from the issue aligner, wrap is modulo depth
    always_comb begin
        for (int i = 0; i < `IBUF_ISSUE_W; i++) begin
            rd_addr[i] = head_ptr_i + ibuf_ptr_t'(lane_offset_i[i]);
            if (lane_valid_i[i]) begin
                rd_entries_o[i] = mem[rd_addr[i]];
            end else begin
                rd_entries_o[i] = NOP_ENTRY;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/ibuf_issue_align.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ibuf_params.svh"

module ibuf_issue_align (
    input  ibuf_pkg::lane_mask_t     decode_ready_i,
    input  ibuf_pkg::lane_avail_t    avail_i,
    output ibuf_pkg::lane_mask_t     lane_valid_o,
    output ibuf_pkg::lane_avail_t    lane_offset_o [`IBUF_ISSUE_W]
);

    import ibuf_pkg::*;

    // Running number of lanes granted below the current one
    lane_avail_t granted;

    //////////////////////////////////////////////////
    // Lane grant
    //////////////////////////////////////////////////

    // Walk lanes from 0 upward. A ready lane is granted while
    // entries remain, and it reads the entry right after those
    // handed to the lanes below, so a sparse ready mask such as
    // 101 still takes head and head+1
    always_comb begin
        granted = '0;
        for (int i = 0; i < `IBUF_ISSUE_W; i++) begin
            lane_offset_o[i] = granted;
            lane_valid_o[i]  = decode_ready_i[i] && (granted < avail_i);
            if (lane_valid_o[i]) begin
                granted = granted + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/ibuf_pkg.sv ====
`default_nettype none

`include "ibuf_params.svh"

package ibuf_pkg;

    //////////////////////////////////////////////////
    // Buffer entry
    //////////////////////////////////////////////////

    // One fetched instruction with its prediction info
    typedef struct packed {
        logic [`IBUF_XLEN-1:0] instr;
        logic [`IBUF_XLEN-1:0] pc;
        logic [`IBUF_XLEN-1:0] imm;
        logic [`IBUF_XLEN-1:0] pred_pc;
        logic                  pred_taken;
    } ibuf_entry_t;

    //////////////////////////////////////////////////
    // Index and mask types
    //////////////////////////////////////////////////

    // Index into the circular store
    typedef logic [$clog2(`IBUF_DEPTH)-1:0] ibuf_ptr_t;

    // Occupancy, 0 to IBUF_DEPTH inclusive
    typedef logic [$clog2(`IBUF_DEPTH):0] ibuf_count_t;

    typedef logic [`IBUF_FETCH_W-1:0] fetch_mask_t;
    typedef logic [`IBUF_ISSUE_W-1:0] lane_mask_t;

    // Entries offered to decode, 0 to IBUF_ISSUE_W
    typedef logic [$clog2(`IBUF_ISSUE_W+1)-1:0] lane_avail_t;

endpackage

`default_nettype wire

// ==== src/ibuf_ptr_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ibuf_params.svh"

module ibuf_ptr_ctrl (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      flush_i,
    input  ibuf_pkg::fetch_mask_t    fetch_valid_i,
    input  ibuf_pkg::lane_mask_t     lane_valid_i,
    output ibuf_pkg::fetch_mask_t    write_en_o,
    output ibuf_pkg::ibuf_ptr_t      tail_ptr_o,
    output ibuf_pkg::ibuf_ptr_t      head_ptr_o,
    output ibuf_pkg::lane_avail_t    avail_o,
    output logic                     fetch_ready_o,
    output ibuf_pkg::ibuf_count_t    count_o,
    output logic                     empty_o,
    output logic                     full_o
);

    import ibuf_pkg::*;

    localparam ibuf_count_t DEPTH_C   = ibuf_count_t'(`IBUF_DEPTH);
    localparam ibuf_count_t FETCH_C   = ibuf_count_t'(`IBUF_FETCH_W);
    localparam ibuf_count_t ISSUE_C   = ibuf_count_t'(`IBUF_ISSUE_W);
    localparam ibuf_count_t FULL_LVL  = DEPTH_C - FETCH_C;

    ibuf_ptr_t   head_ptr;
    ibuf_ptr_t   tail_ptr;
    ibuf_count_t count;

    ibuf_count_t free_space;
    ibuf_count_t num_write;
    ibuf_count_t num_read;

    //////////////////////////////////////////////////
    // Fetch back-pressure
    //////////////////////////////////////////////////

    // Room for a whole bundle is required before accepting any slot
    assign free_space    = DEPTH_C - count;
    assign fetch_ready_o = !flush_i && (free_space >= FETCH_C);
    assign write_en_o    = fetch_ready_o ? fetch_valid_i : '0;

    // Slots written and lanes consumed this cycle
    always_comb begin
        num_write = '0;
        for (int i = 0; i < `IBUF_FETCH_W; i++) begin
            num_write = num_write + ibuf_count_t'(write_en_o[i]);
        end
    end

    always_comb begin
        num_read = '0;
        for (int i = 0; i < `IBUF_ISSUE_W; i++) begin
            num_read = num_read + ibuf_count_t'(lane_valid_i[i]);
        end
    end

    //////////////////////////////////////////////////
    // Decode availability
    //////////////////////////////////////////////////

    // Nothing offered to decode while flushing
    always_comb begin
        if (flush_i) begin
            avail_o = '0;
        end else if (count >= ISSUE_C) begin
            avail_o = lane_avail_t'(ISSUE_C);
        end else begin
            avail_o = lane_avail_t'(count);
        end
    end

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////

    // Pointer wrap comes for free with a power-of-two depth
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (flush_i) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            tail_ptr <= tail_ptr + ibuf_ptr_t'(num_write);
            head_ptr <= head_ptr + ibuf_ptr_t'(num_read);
            count    <= count + num_write - num_read;
        end
    end

    assign tail_ptr_o = tail_ptr;
    assign head_ptr_o = head_ptr;
    assign count_o    = count;

    // Status flags
    assign empty_o = (count == '0);
    assign full_o  = (count >= FULL_LVL);

endmodule

`default_nettype wire

// ==== src/instr_buffer_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ibuf_params.svh"

module instr_buffer_top (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      flush_i,

    // Fetch side
    input  ibuf_pkg::fetch_mask_t    fetch_valid_i,
    input  ibuf_pkg::ibuf_entry_t    fetch_entries_i [`IBUF_FETCH_W],
    output logic                     fetch_ready_o,

    // Decode side
    input  ibuf_pkg::lane_mask_t     decode_ready_i,
    output ibuf_pkg::lane_mask_t     decode_valid_o,
    output ibuf_pkg::ibuf_entry_t    decode_entries_o [`IBUF_ISSUE_W],

    // Status
    output logic                     buffer_empty_o,
    output logic                     buffer_full_o,
    output ibuf_pkg::ibuf_count_t    occupancy_o
);

    import ibuf_pkg::*;

    ibuf_ptr_t   tail_ptr;
    ibuf_ptr_t   head_ptr;
    lane_avail_t avail;
    fetch_mask_t write_en;
    lane_mask_t  lane_valid;
    lane_avail_t lane_offset [`IBUF_ISSUE_W];

    //////////////////////////////////////////////////
    // Pointer control and flow control
    //////////////////////////////////////////////////

    ibuf_ptr_ctrl u_ptr_ctrl (
        .clk           (clk),
        .reset         (reset),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid_i),
        .lane_valid_i  (lane_valid),
        .write_en_o    (write_en),
        .tail_ptr_o    (tail_ptr),
        .head_ptr_o    (head_ptr),
        .avail_o       (avail),
        .fetch_ready_o (fetch_ready_o),
        .count_o       (occupancy_o),
        .empty_o       (buffer_empty_o),
        .full_o        (buffer_full_o)
    );

    // Decode lane mapping
    ibuf_issue_align u_issue_align (
        .decode_ready_i (decode_ready_i),
        .avail_i        (avail),
        .lane_valid_o   (lane_valid),
        .lane_offset_o  (lane_offset)
    );

    // Entry storage
    ibuf_entry_ram u_entry_ram (
        .clk           (clk),
        .write_en_i    (write_en),
        .tail_ptr_i    (tail_ptr),
        .wr_entries_i  (fetch_entries_i),
        .head_ptr_i    (head_ptr),
        .lane_valid_i  (lane_valid),
        .lane_offset_i (lane_offset),
        .rd_entries_o  (decode_entries_o)
    );

    assign decode_valid_o = lane_valid;

endmodule

`default_nettype wire

// ==== tb/tb_instr_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ibuf_params.svh"

module tb_instr_buffer;

    import ibuf_pkg::*;

    // Tests take roughly 350 cycles, 2000 leaves a wide margin
    localparam int MAX_CYCLES = 2000;

    logic        clk;
    logic        reset;
    logic        flush_i;
    fetch_mask_t fetch_valid_i;
    ibuf_entry_t fetch_entries_i [`IBUF_FETCH_W];
    logic        fetch_ready_o;
    lane_mask_t  decode_ready_i;
    lane_mask_t  decode_valid_o;
    ibuf_entry_t decode_entries_o [`IBUF_ISSUE_W];
    logic        buffer_empty_o;
    logic        buffer_full_o;
    ibuf_count_t occupancy_o;

    // Reference model of the stored entries, oldest first
    ibuf_entry_t model_q [$];
    int unsigned next_seq;
    int          errors;
    int          cycle_cnt;

    instr_buffer_top u_instr_buffer_top (
        .clk              (clk),
        .reset            (reset),
        .flush_i          (flush_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_entries_i  (fetch_entries_i),
        .fetch_ready_o    (fetch_ready_o),
        .decode_ready_i   (decode_ready_i),
        .decode_valid_o   (decode_valid_o),
        .decode_entries_o (decode_entries_o),
        .buffer_empty_o   (buffer_empty_o),
        .buffer_full_o    (buffer_full_o),
        .occupancy_o      (occupancy_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d errors, tests did not finish",
                     cycle_cnt, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Entry helpers
    //////////////////////////////////////////////////

    // All fields follow from the sequence number
    function automatic ibuf_entry_t make_entry(input int unsigned seq);
        ibuf_entry_t e;
        e.pc         = 32'h0000_1000 + (seq << 2);
        e.instr      = {seq[19:0], 12'h0b3};
        e.imm        = (seq * 32'd7) ^ 32'h0000_a5a5;
        e.pred_pc    = e.pc + 32'd8;
        e.pred_taken = seq[0];
        return e;
    endfunction

    function automatic ibuf_entry_t nop_entry();
        ibuf_entry_t e;
        e            = '0;
        e.instr      = `IBUF_NOP;
        return e;
    endfunction

    //////////////////////////////////////////////////
    // One clock cycle against the model
    //////////////////////////////////////////////////

    task automatic run_cycle(input logic flush, input fetch_mask_t fmask,
                             input lane_mask_t dready);
        ibuf_entry_t exp_ent [`IBUF_ISSUE_W];
        lane_mask_t  exp_valid;
        logic        exp_ready;
        int          size;
        int          avail;
        int          granted;
        @(negedge clk);
        flush_i        = flush;
        fetch_valid_i  = fmask;
        decode_ready_i = dready;
        for (int i = 0; i < `IBUF_FETCH_W; i++) begin
            fetch_entries_i[i] = make_entry(next_seq + i);
        end
        #5;
        size      = model_q.size();
        exp_ready = !flush && ((`IBUF_DEPTH - size) >= `IBUF_FETCH_W);
        avail     = flush ? 0 : ((size < `IBUF_ISSUE_W) ? size : `IBUF_ISSUE_W);
        granted   = 0;
        for (int i = 0; i < `IBUF_ISSUE_W; i++) begin
            exp_valid[i] = 1'b0;
            exp_ent[i]   = nop_entry();
            if (dready[i] && (granted < avail)) begin
                exp_valid[i] = 1'b1;
                exp_ent[i]   = model_q[granted];
                granted      = granted + 1;
            end
        end
        if (fetch_ready_o !== exp_ready) begin
            $display("ERROR fetch_ready_o: got %h, expected %h", fetch_ready_o, exp_ready);
            errors++;
        end
        if (occupancy_o !== ibuf_count_t'(size)) begin
            $display("ERROR occupancy_o: got %h, expected %h", occupancy_o, size);
            errors++;
        end
        if (buffer_empty_o !== (size == 0)) begin
            $display("ERROR buffer_empty_o: got %h, expected %h", buffer_empty_o, size == 0);
            errors++;
        end
        if (buffer_full_o !== (size >= `IBUF_DEPTH - `IBUF_FETCH_W)) begin
            $display("ERROR buffer_full_o: got %h, expected %h", buffer_full_o,
                     size >= `IBUF_DEPTH - `IBUF_FETCH_W);
            errors++;
        end
        if (decode_valid_o !== exp_valid) begin
            $display("ERROR decode_valid_o: got %h, expected %h", decode_valid_o, exp_valid);
            errors++;
        end
        for (int i = 0; i < `IBUF_ISSUE_W; i++) begin
            if (decode_entries_o[i] !== exp_ent[i]) begin
                $display("ERROR decode_entries_o[%0d]: got %h, expected %h",
                         i, decode_entries_o[i], exp_ent[i]);
                errors++;
            end
        end
        @(posedge clk);
        if (flush) begin
            model_q.delete();
        end else begin
            for (int i = 0; i < granted; i++) begin
                void'(model_q.pop_front());
            end
            if (exp_ready) begin
                for (int i = 0; i < `IBUF_FETCH_W; i++) begin
                    if (fmask[i]) begin
                        model_q.push_back(fetch_entries_i[i]);
                    end
                end
                next_seq = next_seq + `IBUF_FETCH_W;
            end
        end
    endtask

    // Empty the buffer with all lanes ready, then look at the DUT state
    task automatic drain_buffer();
        for (int n = 0; n < 8 && model_q.size() > 0; n++) begin
            run_cycle(1'b0, 3'b000, 3'b111);
        end
        // Registers have settled just after the edge
        #1;
        if (occupancy_o !== '0) begin
            $display("ERROR occupancy_o: got %h, expected %h after draining",
                     occupancy_o, 0);
            errors++;
        end
        if (buffer_empty_o !== 1'b1) begin
            $display("ERROR buffer_empty_o: got %h, expected %h after draining",
                     buffer_empty_o, 1'b1);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic after_reset();
        run_cycle(1'b0, 3'b000, 3'b111);
    endtask

    // Gaps in the fetch mask must not leave holes
    task automatic fetch_compaction();
        run_cycle(1'b0, 3'b111, 3'b000);
        run_cycle(1'b0, 3'b101, 3'b000);
        run_cycle(1'b0, 3'b010, 3'b000);
        run_cycle(1'b0, 3'b110, 3'b000);
        drain_buffer();
    endtask

    // Four entries, then sparse ready masks
    task automatic sparse_decode_ready();
        run_cycle(1'b0, 3'b111, 3'b000);
        run_cycle(1'b0, 3'b100, 3'b000);
        run_cycle(1'b0, 3'b000, 3'b001);
        run_cycle(1'b0, 3'b000, 3'b101);
        run_cycle(1'b0, 3'b000, 3'b110);
        run_cycle(1'b0, 3'b000, 3'b100);
        run_cycle(1'b0, 3'b000, 3'b111);
    endtask

    // Count goes 12 then 13 (full) then 15 (no room for a bundle)
    task automatic full_backpressure();
        repeat (4) run_cycle(1'b0, 3'b111, 3'b000);
        run_cycle(1'b0, 3'b001, 3'b000);
        run_cycle(1'b0, 3'b011, 3'b000);
        repeat (2) run_cycle(1'b0, 3'b111, 3'b000);
        drain_buffer();
    endtask

    task automatic flush_recovery();
        run_cycle(1'b0, 3'b111, 3'b000);
        run_cycle(1'b0, 3'b011, 3'b000);
        run_cycle(1'b1, 3'b111, 3'b111);
        run_cycle(1'b0, 3'b000, 3'b111);
        run_cycle(1'b0, 3'b111, 3'b000);
        drain_buffer();
    endtask

    task automatic random_traffic();
        fetch_mask_t fmask;
        lane_mask_t  dready;
        logic        flush;
        for (int n = 0; n < 300; n++) begin
            fmask  = fetch_mask_t'($urandom % 8);
            dready = lane_mask_t'($urandom % 8);
            flush  = (($urandom % 32) == 0);
            run_cycle(flush, fmask, dready);
        end
        drain_buffer();
    endtask

    initial begin
        void'($urandom(30049));
        reset          = 1'b0;
        flush_i        = 1'b0;
        fetch_valid_i  = '0;
        decode_ready_i = '0;
        for (int i = 0; i < `IBUF_FETCH_W; i++) begin
            fetch_entries_i[i] = '0;
        end
        next_seq  = 0;
        errors    = 0;
        cycle_cnt = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        after_reset();
        fetch_compaction();
        sparse_decode_ready();
        full_backpressure();
        flush_recovery();
        random_traffic();

        $display("Tests done after %0d cycles, errors: %0d", cycle_cnt, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
src/ibuf_pkg.sv
src/ibuf_ptr_ctrl.sv
src/ibuf_entry_ram.sv
src/ibuf_issue_align.sv
src/instr_buffer_top.sv
tb/tb_instr_buffer.sv
